// File: list.f
rtl/driveCfgPkg.sv
rtl/driveTypesPkg.sv
rtl/tickGen.sv
rtl/inputSync.sv
rtl/commandSelect.sv
rtl/faultMonitor.sv
rtl/motionControl.sv
rtl/valveDriveTop.sv
sim/valveDriveTb.sv

// File: rtl/commandSelect.sv
`default_nettype none
`timescale 1ns/1ps

module commandSelect
    import driveCfgPkg::*;
    import driveTypesPkg::*;
(
    input  logic                  iClk,
    input  logic                  iRst,
    input  logic                  tick,
    input  panelCmdT              panel,
    input  remoteCmdT             remote,
    input  plantT                 plant,
    output logic                  turnedOn,
    output logic                  openReq,
    output logic                  closeReq,
    output logic                  remoteMode,
    output logic [speedWidth-1:0] speed
);

    logic [speedWidth-1:0] target;

    // Remote only when the selector is off local
    assign remoteMode = plant.remoteSel & ~plant.localSel;
    assign target     = remoteMode ? remote.speed : speedWidth'(localSpeed);

    //////////////////////////////////////////////////////////////////////
    // Source selection
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            turnedOn <= 1'b0;
            openReq  <= 1'b0;
            closeReq <= 1'b0;
        end else if (remoteMode) begin
            turnedOn <= remote.driveOn;
            openReq  <= remote.move & ~remote.close;
            closeReq <= remote.move & remote.close;
        end else begin
            if (panel.turnOff) begin
                turnedOn <= 1'b0;   // Off key wins over on
            end else if (panel.turnOn) begin
                turnedOn <= 1'b1;
            end
            openReq  <= panel.open;
            closeReq <= panel.close;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Speed ramp
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            speed <= '0;
        end else if (tick) begin
            if (speed < target) begin
                if (target - speed > speedWidth'(speedStep)) begin
                    speed <= speed + speedWidth'(speedStep);
                end else begin
                    speed <= target;   // Last partial step
                end
            end else if (speed > target) begin
                if (speed - target > speedWidth'(speedStep)) begin
                    speed <= speed - speedWidth'(speedStep);
                end else begin
                    speed <= target;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/driveCfgPkg.sv
`default_nettype none

package driveCfgPkg;

    //////////////////////////////////////////////////////////////////////
    // Timing, scaled down for simulation
    //////////////////////////////////////////////////////////////////////
    localparam int tickDivider         = 100;  // Clock cycles per 100 Hz tick
    localparam int debounceTicks       = 3;    // Steady ticks before an input is taken
    localparam int starterTimeoutTicks = 20;   // Starter feedback window after switch-on
    localparam int reverseDwellTicks   = 5;    // Idle time before a reversal
    localparam int brakeHoldTicks      = 2;    // Brake release kept after the stop

    //////////////////////////////////////////////////////////////////////
    // Word sizes and speed profile
    //////////////////////////////////////////////////////////////////////
    localparam int speedWidth     = 10;
    localparam int speedStep      = 64;   // Ramp increment per tick
    localparam int localSpeed     = 752;  // Fixed setpoint from the panel
    localparam int faultCodeWidth = 4;

endpackage

`default_nettype wire

// File: rtl/driveTypesPkg.sv
`default_nettype none

package driveTypesPkg;
    import driveCfgPkg::*;

    // Local panel keys
    typedef struct packed {
        logic turnOn;
        logic turnOff;
        logic open;
        logic close;
    } panelCmdT;

    // Command word from the control system, already decoded
    typedef struct packed {
        logic                  driveOn;
        logic                  close;    // 0 selects open
        logic                  move;
        logic [speedWidth-1:0] speed;
    } remoteCmdT;

    typedef struct packed {
        logic openLimit;
        logic closeLimit;
        logic openOvertravel;
        logic closeOvertravel;
    } limitT;

    // Plant feedback, phase bits high while the phase is present
    typedef struct packed {
        logic emergency;
        logic inverterFault;
        logic starterOn;
        logic phaseL1;
        logic phaseL2;
        logic phaseL3;
        logic localSel;
        logic remoteSel;
    } plantT;

    // Lower code wins on a tie
    typedef enum logic [faultCodeWidth-1:0] {
        faultNone      = 0,
        faultEmergency = 1,
        faultInverter  = 2,
        faultStarter   = 3,
        faultPhaseL1   = 4,
        faultPhaseL2   = 5,
        faultPhaseL3   = 6
    } faultCodeT;

    typedef struct packed {
        logic      turnedOn;
        logic      remoteMode;
        logic      movingOpen;
        logic      movingClose;
        faultCodeT faultCode;
        limitT     limits;
    } statusT;

endpackage

`default_nettype wire

// File: rtl/faultMonitor.sv
`default_nettype none
`timescale 1ns/1ps

module faultMonitor
    import driveCfgPkg::*;
    import driveTypesPkg::*;
(
    input  logic      iClk,
    input  logic      iRst,
    input  logic      tick,
    input  plantT     plant,
    input  logic      turnedOn,
    input  logic      clearReq,
    output faultCodeT faultCode
);

    typedef logic [$clog2(starterTimeoutTicks + 1)-1:0] starterCountT;
    typedef logic [$clog2(debounceTicks + 2)-1:0]       blankCountT;

    starterCountT starterCount;
    blankCountT   blankCount;
    logic         starterTimeout;
    logic         phaseValid;
    faultCodeT    activeCode;

    //////////////////////////////////////////////////////////////////////
    // Magnetic starter watchdog
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            starterCount <= '0;
        end else if (!turnedOn || plant.starterOn) begin
            starterCount <= '0;
        end else if (tick && !starterTimeout) begin
            starterCount <= starterCount + 1'b1;
        end
    end

    assign starterTimeout = (starterCount == starterCountT'(starterTimeoutTicks));

    // Filtered inputs come up at zero, which reads as lost phases
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            blankCount <= '0;
        end else if (tick && !phaseValid) begin
            blankCount <= blankCount + 1'b1;
        end
    end

    assign phaseValid = (blankCount == blankCountT'(debounceTicks + 1));

    //////////////////////////////////////////////////////////////////////
    // Priority and latch
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        activeCode = faultNone;
        if (plant.emergency)                    activeCode = faultEmergency;
        else if (plant.inverterFault)           activeCode = faultInverter;
        else if (starterTimeout)                activeCode = faultStarter;
        else if (phaseValid && !plant.phaseL1)  activeCode = faultPhaseL1;
        else if (phaseValid && !plant.phaseL2)  activeCode = faultPhaseL2;
        else if (phaseValid && !plant.phaseL3)  activeCode = faultPhaseL3;
    end

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            faultCode <= faultNone;
        end else if (faultCode == faultNone) begin
            faultCode <= activeCode;   // First fault sticks
        end else if (clearReq && activeCode == faultNone) begin
            faultCode <= faultNone;
        end
    end

endmodule

`default_nettype wire

// File: rtl/inputSync.sv
`default_nettype none
`timescale 1ns/1ps

module inputSync
    import driveCfgPkg::*;
#(
    parameter type syncT = logic
) (
    input  logic iClk,
    input  logic iRst,
    input  logic tick,
    input  syncT raw,
    output syncT clean
);

    typedef logic [$clog2(debounceTicks + 1)-1:0] steadyCountT;

    syncT        syncMeta;     // First stage, may go metastable
    syncT        syncStable;
    syncT        heldValue;    // Candidate waiting for the debounce window
    steadyCountT steadyCount;

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            syncMeta    <= '0;
            syncStable  <= '0;
            heldValue   <= '0;
            steadyCount <= '0;
            clean       <= '0;
        end else begin
            syncMeta   <= raw;
            syncStable <= syncMeta;

            // Any bit change restarts the window
            if (syncStable != heldValue) begin
                heldValue   <= syncStable;
                steadyCount <= '0;
            end else if (tick && steadyCount != steadyCountT'(debounceTicks)) begin
                steadyCount <= steadyCount + 1'b1;
                if (steadyCount == steadyCountT'(debounceTicks - 1)) begin
                    clean <= heldValue;   // Window complete
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/motionControl.sv
`default_nettype none
`timescale 1ns/1ps

module motionControl
    import driveCfgPkg::*;
    import driveTypesPkg::*;
(
    input  logic                  iClk,
    input  logic                  iRst,
    input  logic                  tick,
    input  logic                  enable,
    input  logic                  openReq,
    input  logic                  closeReq,
    input  limitT                 limits,
    input  logic [speedWidth-1:0] speed,
    output logic                  motorOpen,
    output logic                  motorClose,
    output logic                  brakeRelease,
    output logic                  speedPwm
);

    typedef logic [$clog2(reverseDwellTicks + 1)-1:0] dwellCountT;
    typedef logic [$clog2(brakeHoldTicks + 1)-1:0]    brakeCountT;

    logic                  lastClose;    // Direction of the last run
    dwellCountT            dwellCount;
    logic                  dwellDone;
    brakeCountT            brakeCount;
    logic                  openRun;
    logic                  closeRun;
    logic [speedWidth-1:0] pwmCount;

    assign dwellDone = (dwellCount == dwellCountT'(reverseDwellTicks));

    // Both keys at once mean stop
    always_comb begin
        openRun  = enable && openReq && !closeReq
                   && !limits.openLimit && !limits.openOvertravel
                   && (!lastClose || dwellDone);
        closeRun = enable && closeReq && !openReq
                   && !limits.closeLimit && !limits.closeOvertravel
                   && (lastClose || dwellDone);
    end

    //////////////////////////////////////////////////////////////////////
    // Direction outputs and reversal dwell
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            motorOpen  <= 1'b0;
            motorClose <= 1'b0;
            lastClose  <= 1'b0;
            dwellCount <= dwellCountT'(reverseDwellTicks);   // Free to start either way
        end else begin
            motorOpen  <= openRun;
            motorClose <= closeRun;

            if (motorOpen || motorClose) begin
                lastClose  <= motorClose;
                dwellCount <= '0;
            end else if (tick && !dwellDone) begin
                dwellCount <= dwellCount + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Brake
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            brakeRelease <= 1'b0;
            brakeCount   <= '0;
        end else if (openRun || closeRun) begin
            brakeRelease <= 1'b1;   // Released together with the motor
            brakeCount   <= '0;
        end else if (brakeRelease && tick) begin
            brakeCount <= brakeCount + 1'b1;
            if (brakeCount == brakeCountT'(brakeHoldTicks - 1)) begin
                brakeRelease <= 1'b0;
            end
        end
    end

    // Speed PWM for the 4-20 mA loop, period of 2^speedWidth cycles
    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            pwmCount <= '0;
            speedPwm <= 1'b0;
        end else begin
            pwmCount <= pwmCount + 1'b1;
            speedPwm <= (pwmCount < speed);
        end
    end

endmodule

`default_nettype wire

// File: rtl/tickGen.sv
`default_nettype none
`timescale 1ns/1ps

module tickGen
    import driveCfgPkg::*;
(
    input  logic iClk,
    input  logic iRst,
    output logic tick
);

    typedef logic [$clog2(tickDivider)-1:0] tickCountT;

    tickCountT tickCount;

    always_ff @(posedge iClk or posedge iRst) begin
        if (iRst) begin
            tickCount <= '0;
            tick      <= 1'b0;
        end else if (tickCount == tickCountT'(tickDivider - 1)) begin
            tickCount <= '0;
            tick      <= 1'b1;   // One-cycle strobe on wrap
        end else begin
            tickCount <= tickCount + 1'b1;
            tick      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/valveDriveTop.sv
`default_nettype none
`timescale 1ns/1ps

module valveDriveTop
    import driveCfgPkg::*;
    import driveTypesPkg::*;
(
    input  logic      iClk,
    input  logic      iRst,
    input  panelCmdT  panelN,
    input  limitT     limitsN,
    input  plantT     plantN,
    input  remoteCmdT remoteCmd,
    output logic      starterN,
    output logic      motorOpenN,
    output logic      motorCloseN,
    output logic      brakeN,
    output logic      speedPwmN,
    output statusT    status
);

    logic                  tick;
    panelCmdT              panelClean;
    limitT                 limitsClean;
    plantT                 plantClean;
    logic                  turnedOn;
    logic                  openReq;
    logic                  closeReq;
    logic                  remoteMode;
    logic [speedWidth-1:0] speed;
    faultCodeT             faultCode;
    logic                  enable;
    logic                  motorOpen;
    logic                  motorClose;
    logic                  brakeRelease;
    logic                  speedPwm;

    tickGen tickUnit (
        .iClk (iClk),
        .iRst (iRst),
        .tick (tick)
    );

    //////////////////////////////////////////////////////////////////////
    // Input filters, internally everything is active high
    //////////////////////////////////////////////////////////////////////
    inputSync #(.syncT(panelCmdT)) panelSync (
        .iClk  (iClk),
        .iRst  (iRst),
        .tick  (tick),
        .raw   (panelCmdT'(~panelN)),
        .clean (panelClean)
    );

    inputSync #(.syncT(limitT)) limitSync (
        .iClk  (iClk),
        .iRst  (iRst),
        .tick  (tick),
        .raw   (limitT'(~limitsN)),
        .clean (limitsClean)
    );

    inputSync #(.syncT(plantT)) plantSync (
        .iClk  (iClk),
        .iRst  (iRst),
        .tick  (tick),
        .raw   (plantT'(~plantN)),
        .clean (plantClean)
    );

    commandSelect cmdSelect (
        .iClk       (iClk),
        .iRst       (iRst),
        .tick       (tick),
        .panel      (panelClean),
        .remote     (remoteCmd),
        .plant      (plantClean),
        .turnedOn   (turnedOn),
        .openReq    (openReq),
        .closeReq   (closeReq),
        .remoteMode (remoteMode),
        .speed      (speed)
    );

    faultMonitor faultUnit (
        .iClk      (iClk),
        .iRst      (iRst),
        .tick      (tick),
        .plant     (plantClean),
        .turnedOn  (turnedOn),
        .clearReq  (panelClean.turnOff),
        .faultCode (faultCode)
    );

    assign enable = turnedOn && (faultCode == faultNone);   // Any fault drops starter and motor

    motionControl motion (
        .iClk         (iClk),
        .iRst         (iRst),
        .tick         (tick),
        .enable       (enable),
        .openReq      (openReq),
        .closeReq     (closeReq),
        .limits       (limitsClean),
        .speed        (speed),
        .motorOpen    (motorOpen),
        .motorClose   (motorClose),
        .brakeRelease (brakeRelease),
        .speedPwm     (speedPwm)
    );

    //////////////////////////////////////////////////////////////////////
    // Output pins and status
    //////////////////////////////////////////////////////////////////////
    assign starterN    = ~enable;
    assign motorOpenN  = ~motorOpen;
    assign motorCloseN = ~motorClose;
    assign brakeN      = ~brakeRelease;
    assign speedPwmN   = ~speedPwm;

    always_comb begin
        status.turnedOn    = turnedOn;
        status.remoteMode  = remoteMode;
        status.movingOpen  = motorOpen;
        status.movingClose = motorClose;
        status.faultCode   = faultCode;
        status.limits      = limitsClean;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module valveDriveTb \
    -f list.f \
    -o valveDriveSim

./obj_dir/valveDriveSim

// File: sim/valveDriveTb.sv
`default_nettype none
`timescale 1ns/1ps

module valveDriveTb
    import driveCfgPkg::*;
    import driveTypesPkg::*;
();

    typedef enum {pinStarter, pinOpen, pinClose, pinBrake, pinPwm, pinRemote, pinNoFault} pinT;

    // Worst input latency plus the two register stages behind the filter
    localparam int settleLimit   = (debounceTicks + 1) * tickDivider + 3 + 4;
    localparam int startupCycles = (debounceTicks + 2) * tickDivider;
    localparam int rampCycles    = ((1 << speedWidth) / speedStep + 2) * tickDivider;
    localparam int pwmPeriod     = 1 << speedWidth;
    localparam int testCycles    = startupCycles
        + 8 * settleLimit + (brakeHoldTicks + reverseDwellTicks + 2) * tickDivider
        + settleLimit + 2 * (rampCycles + pwmPeriod)
        + 6 * settleLimit
        + 2 * settleLimit + (starterTimeoutTicks + 1) * tickDivider
        + 4 * settleLimit + (reverseDwellTicks + 2) * tickDivider;
    localparam int timeoutCycles = 2 * testCycles;

    logic        iClk;
    logic        iRst;
    panelCmdT    panelN;
    limitT       limitsN;
    plantT       plantN;
    remoteCmdT   remoteCmd;
    logic        starterN;
    logic        motorOpenN;
    logic        motorCloseN;
    logic        brakeN;
    logic        speedPwmN;
    statusT      status;

    panelCmdT    panelKeys;    // Active-high copies of the pin levels
    limitT       limitHi;
    plantT       plantHi;
    remoteCmdT   remoteCur;
    int          cycleCount;

    valveDriveTop dut0 (
        .iClk        (iClk),
        .iRst        (iRst),
        .panelN      (panelN),
        .limitsN     (limitsN),
        .plantN      (plantN),
        .remoteCmd   (remoteCmd),
        .starterN    (starterN),
        .motorOpenN  (motorOpenN),
        .motorCloseN (motorCloseN),
        .brakeN      (brakeN),
        .speedPwmN   (speedPwmN),
        .status      (status)
    );

    always #10 iClk = ~iClk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic logic readPin(input pinT pin);
        case (pin)
            pinStarter: return starterN;
            pinOpen:    return motorOpenN;
            pinClose:   return motorCloseN;
            pinBrake:   return brakeN;
            pinPwm:     return speedPwmN;
            pinRemote:  return status.remoteMode;
            pinNoFault: return (status.faultCode == faultNone);
            default:    return 1'bx;
        endcase
    endfunction

    // Pins are active low so the levels go out inverted
    task automatic driveInputs();
        @(posedge iClk);
        panelN    <= panelCmdT'(~panelKeys);
        limitsN   <= limitT'(~limitHi);
        plantN    <= plantT'(~plantHi);
        remoteCmd <= remoteCur;
    endtask

    task automatic expectPin(input pinT pin, input logic level, input string what);
        assert (readPin(pin) === level)
        else abortRun($sformatf("ERR at %0t: %s is %b, expected %b",
                                $time, what, readPin(pin), level));
    endtask

    task automatic waitPin(input pinT pin, input logic level, input int limit,
                           input string what, output int cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge iClk);   // Outputs settle between edges
            n++;
            seen = (readPin(pin) === level);
        end
        assert (seen)
        else abortRun($sformatf("ERR at %0t: %s not seen within %0d cycles",
                                $time, what, limit));
        cycles = n;
    endtask

    task automatic countPwmLow(output int lows);
        lows = 0;
        repeat (pwmPeriod) begin
            @(negedge iClk);
            if (speedPwmN === 1'b0) lows++;
        end
    endtask

    task automatic switchOn();
        int waited;
        panelKeys.turnOn = 1'b1;
        driveInputs();
        waitPin(pinStarter, 1'b0, settleLimit, "starterN low", waited);
        panelKeys.turnOn = 1'b0;
        driveInputs();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    task automatic checkResetState();
        int n;
        $display("Test: reset state");
        for (n = 0; n < startupCycles; n++) begin
            @(negedge iClk);
            expectPin(pinStarter, 1'b1, "starterN");
            expectPin(pinOpen, 1'b1, "motorOpenN");
            expectPin(pinClose, 1'b1, "motorCloseN");
            expectPin(pinBrake, 1'b1, "brakeN");
            expectPin(pinNoFault, 1'b1, "fault-free status");
            assert (status.turnedOn == 1'b0)
            else abortRun($sformatf("ERR at %0t: turnedOn set after reset", $time));
            if (n < tickDivider - 10) expectPin(pinPwm, 1'b1, "speedPwmN at zero speed");
        end
    endtask

    task automatic runLocalOpenClose();
        int waited;
        $display("Test: local open and close");
        switchOn();
        panelKeys.open = 1'b1;
        driveInputs();
        waitPin(pinOpen, 1'b0, settleLimit, "motorOpenN low", waited);
        expectPin(pinBrake, 1'b0, "brakeN while opening");
        assert (status.movingOpen && !status.movingClose)
        else abortRun($sformatf("ERR at %0t: status does not show opening", $time));

        limitHi.openLimit = 1'b1;   // Valve reaches open end
        driveInputs();
        waitPin(pinOpen, 1'b1, settleLimit, "open stop at limit", waited);
        expectPin(pinBrake, 1'b0, "brakeN right after stop");
        waitPin(pinBrake, 1'b1, (brakeHoldTicks + 1) * tickDivider + 2, "brake engage", waited);

        panelKeys.open  = 1'b0;
        panelKeys.close = 1'b1;
        driveInputs();
        waitPin(pinClose, 1'b0, settleLimit + reverseDwellTicks * tickDivider,
                "motorCloseN low", waited);
        expectPin(pinBrake, 1'b0, "brakeN while closing");
        assert (status.movingClose && !status.movingOpen)
        else abortRun($sformatf("ERR at %0t: status does not show closing", $time));

        limitHi.openLimit  = 1'b0;
        limitHi.closeLimit = 1'b1;
        driveInputs();
        waitPin(pinClose, 1'b1, settleLimit, "close stop at limit", waited);
        assert (status.limits.closeLimit == 1'b1)
        else abortRun($sformatf("ERR at %0t: close limit missing in status", $time));

        panelKeys.close    = 1'b0;
        limitHi.closeLimit = 1'b0;
        driveInputs();
    endtask

    task automatic checkRemoteSpeed();
        int waited;
        int setpoint;
        int lows;
        int round;
        $display("Test: remote speed");
        plantHi.localSel  = 1'b0;
        plantHi.remoteSel = 1'b1;
        for (round = 0; round < 2; round++) begin
            setpoint        = int'($urandom() % (1 << speedWidth));
            remoteCur.speed = speedWidth'(setpoint);
            driveInputs();
            if (round == 0) waitPin(pinRemote, 1'b1, settleLimit, "remote mode", waited);
            repeat (rampCycles) @(negedge iClk);   // Ramp covers full scale by now
            countPwmLow(lows);
            assert (lows == setpoint)
            else abortRun($sformatf("ERR at %0t: PWM low for %0d cycles, expected %0d",
                                    $time, lows, setpoint));
        end
        plantHi.localSel  = 1'b1;
        plantHi.remoteSel = 1'b0;
        driveInputs();
        waitPin(pinRemote, 1'b0, settleLimit, "local mode", waited);
    endtask

    task automatic checkFaultLatch();
        int waited;
        $display("Test: fault priority and latch");
        switchOn();
        panelKeys.open = 1'b1;
        driveInputs();
        waitPin(pinOpen, 1'b0, settleLimit, "motorOpenN low", waited);

        // Inverter fault and L3 loss at the same edge
        plantHi.inverterFault = 1'b1;
        plantHi.phaseL3       = 1'b0;
        driveInputs();
        waitPin(pinNoFault, 1'b0, settleLimit, "fault code", waited);
        assert (status.faultCode == faultInverter)
        else abortRun($sformatf("ERR at %0t: fault code %0d, expected %0d",
                                $time, status.faultCode, faultInverter));
        expectPin(pinStarter, 1'b1, "starterN under fault");
        @(negedge iClk);
        expectPin(pinOpen, 1'b1, "motorOpenN under fault");
        expectPin(pinClose, 1'b1, "motorCloseN under fault");

        plantHi.inverterFault = 1'b0;
        plantHi.phaseL3       = 1'b1;
        panelKeys.open        = 1'b0;
        driveInputs();
        repeat (settleLimit + tickDivider) begin
            @(negedge iClk);
            assert (status.faultCode == faultInverter)
            else abortRun($sformatf("ERR at %0t: latched code lost, got %0d",
                                    $time, status.faultCode));
        end

        panelKeys.turnOff = 1'b1;
        driveInputs();
        waitPin(pinNoFault, 1'b1, settleLimit, "fault clear", waited);
        panelKeys.turnOff = 1'b0;
        driveInputs();
    endtask

    task automatic checkStarterWatchdog();
        int waited;
        $display("Test: starter watchdog");
        plantHi.starterOn = 1'b0;   // Starter never answers
        panelKeys.turnOn  = 1'b1;
        driveInputs();
        waitPin(pinStarter, 1'b0, settleLimit, "starterN low", waited);
        waitPin(pinNoFault, 1'b0, starterTimeoutTicks * tickDivider + 4, "starter fault", waited);
        assert (status.faultCode == faultStarter)
        else abortRun($sformatf("ERR at %0t: fault code %0d, expected %0d",
                                $time, status.faultCode, faultStarter));
        assert (waited >= (starterTimeoutTicks - 1) * tickDivider)
        else abortRun($sformatf("ERR at %0t: starter fault after only %0d cycles",
                                $time, waited));
        expectPin(pinStarter, 1'b1, "starterN after timeout");

        plantHi.starterOn = 1'b1;
        panelKeys.turnOn  = 1'b0;
        panelKeys.turnOff = 1'b1;
        driveInputs();
        waitPin(pinNoFault, 1'b1, settleLimit, "fault clear", waited);
        panelKeys.turnOff = 1'b0;
        driveInputs();
    endtask

    task automatic checkReversalDwell();
        int waited;
        $display("Test: reversal dwell");
        switchOn();
        panelKeys.open = 1'b1;
        driveInputs();
        waitPin(pinOpen, 1'b0, settleLimit, "motorOpenN low", waited);

        panelKeys.open  = 1'b0;
        panelKeys.close = 1'b1;
        driveInputs();
        waitPin(pinOpen, 1'b1, settleLimit, "open stop", waited);
        repeat ((reverseDwellTicks - 1) * tickDivider) begin
            @(negedge iClk);
            expectPin(pinOpen, 1'b1, "motorOpenN in dwell");
            expectPin(pinClose, 1'b1, "motorCloseN in dwell");
        end
        waitPin(pinClose, 1'b0, 2 * tickDivider + 2, "close after dwell", waited);

        panelKeys.close   = 1'b0;
        panelKeys.turnOff = 1'b1;
        driveInputs();
        waitPin(pinStarter, 1'b1, settleLimit, "starterN high", waited);
        panelKeys.turnOff = 1'b0;
        driveInputs();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and run limit
    //////////////////////////////////////////////////////////////////////
    initial begin
        iClk      = 1'b0;
        iRst      = 1'b1;
        panelKeys = '0;
        limitHi   = '0;
        remoteCur = '0;
        plantHi           = '0;
        plantHi.starterOn = 1'b1;
        plantHi.phaseL1   = 1'b1;
        plantHi.phaseL2   = 1'b1;
        plantHi.phaseL3   = 1'b1;
        plantHi.localSel  = 1'b1;
        panelN    = panelCmdT'(~panelKeys);
        limitsN   = limitT'(~limitHi);
        plantN    = plantT'(~plantHi);
        remoteCmd = remoteCur;
        void'($urandom(32'h0db7_0508));

        repeat (10) @(posedge iClk);
        iRst <= 1'b0;

        checkResetState();
        runLocalOpenClose();
        checkRemoteSpeed();
        checkFaultLatch();
        checkStarterWatchdog();
        checkReversalDwell();

        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge iClk);
            cycleCount++;
        end
        abortRun("Timeout: the tests did not finish within the cycle limit");
    end

endmodule

`default_nettype wire
